/* bench/mem_tile_asserts.sv */
//////////////////////////////////////////////////
// Handshake rules of the tile's outside port
// Counts accepted requests against responses
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "memtile_config.svh"

module mem_tile_asserts (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     a_req_i,
  input logic                     a_gnt_o,
  input logic                     r_valid_o,
  input logic                     r_ready_i,
  input memtile_pkg::obi_r_chan_t r_chan_o
);

  logic [7:0] outstanding_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 8'(a_req_i && a_gnt_o) - 8'(r_valid_o && r_ready_i);
    end
  end

  quiet_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> (!a_gnt_o && !r_valid_o))
    else $error("grant or response valid during reset");

  rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_chan_o)))
    else $error("response changed while stalled");

  rsp_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    r_valid_o |-> (outstanding_q != 0))
    else $error("response without an accepted request");

endmodule

bind mem_tile mem_tile_asserts u_asserts (.*);

/* bench/mem_tile_tb.sv */
//////////////////////////////////////////////////
// Directed testbench for the memory tile
// Shadow byte model with its own reservation
// Memory is filled first, SRAM powers up unknown
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "memtile_config.svh"

module mem_tile_tb;

  import memtile_pkg::*;

  localparam int unsigned TileBytes =
    `MEMTILE_BANK_ROWS * `MEMTILE_WORDS_PER_MACRO * `MEMTILE_DATA_WIDTH / 8;
  localparam int unsigned NumWords      = TileBytes / 8;
  localparam int unsigned TimeoutCycles = 20000;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        a_req_i;
  logic        a_gnt_o;
  obi_a_chan_t a_chan_i;
  logic        r_valid_o;
  logic        r_ready_i;
  obi_r_chan_t r_chan_o;

  logic [7:0]  shadow [TileBytes];
  logic        res_valid;
  int unsigned res_word;
  obi_r_chan_t exp_q [$];
  data_t       last_rdata;
  string       cur_test = "reset";
  logic [31:0] rng_q = 32'hcf09;
  logic [31:0] rdy_q;
  logic        bp_en = 1'b0;
  int unsigned cycle_cnt = 0;

  mem_tile u_dut (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_q = xorshift(rng_q);
    return rng_q;
  endfunction

  function automatic int unsigned word_index(input addr_t addr);
    return (addr % TileBytes) / 8;
  endfunction

  function automatic data_t get_word(input int unsigned w);
    data_t d;
    for (int b = 0; b < 8; b++) begin
      d[b*8+:8] = shadow[w*8+b];
    end
    return d;
  endfunction

  function automatic void put_half(input int unsigned w, input int unsigned h,
                                   input logic [31:0] v);
    for (int b = 0; b < 4; b++) begin
      shadow[w*8+h*4+b] = v[b*8+:8];
    end
  endfunction

  // Reference behavior of one accepted request, in request order
  function automatic obi_r_chan_t apply_model(input obi_a_chan_t req);
    int unsigned w;
    int unsigned h;
    data_t       word;
    logic [31:0] old_v;
    logic [31:0] op_v;
    logic [31:0] new_v;
    logic        hit;
    obi_r_chan_t rsp;
    w     = word_index(req.addr);
    h     = 32'(req.addr[2]);
    word  = get_word(w);
    old_v = word[h*32+:32];
    op_v  = req.wdata[h*32+:32];
    hit   = res_valid && (res_word == w);
    rsp   = '0;
    rsp.rid = req.aid;
    case (req.atop)
      ATOP_NONE: begin
        if (req.we) begin
          for (int b = 0; b < 8; b++) begin
            if (req.be[b]) begin
              shadow[w*8+b] = req.wdata[b*8+:8];
            end
          end
          if (hit) begin
            res_valid = 1'b0;
          end
        end else begin
          rsp.rdata = word;
        end
      end
      ATOP_LR: begin
        res_valid = 1'b1;
        res_word  = w;
        rsp.rdata[h*32+:32] = old_v;
        rsp.exokay = 1'b1;
      end
      ATOP_SC: begin
        res_valid = 1'b0;
        if (hit) begin
          put_half(w, h, op_v);
          rsp.exokay = 1'b1;
        end else begin
          rsp.rdata[h*32+:32] = 32'd1;
        end
      end
      default: begin
        case (req.atop)
          ATOP_ADD:  new_v = old_v + op_v;
          ATOP_AND:  new_v = old_v & op_v;
          ATOP_OR:   new_v = old_v | op_v;
          ATOP_MAX:  new_v = ($signed(old_v) > $signed(op_v)) ? old_v : op_v;
          ATOP_MINU: new_v = (old_v < op_v) ? old_v : op_v;
          default:   new_v = op_v;
        endcase
        put_half(w, h, new_v);
        if (hit) begin
          res_valid = 1'b0;
        end
        rsp.rdata[h*32+:32] = old_v;
      end
    endcase
    return rsp;
  endfunction

  task automatic check_rsp(input string name, input obi_r_chan_t exp, input obi_r_chan_t act);
    if (exp.rdata !== act.rdata || exp.rid !== act.rid || exp.exokay !== act.exokay) begin
      $display("CHECK FAILED %s: expected rdata %h rid %h exokay %b, %s", name,
               exp.rdata, exp.rid, exp.exokay,
               $sformatf("actual rdata %h rid %h exokay %b", act.rdata, act.rid, act.exokay));
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  //////////////////////////////////////////////////
  // Bus driving and response monitor
  //////////////////////////////////////////////////

  task automatic send(input obi_a_chan_t req);
    #2;
    a_req_i  = 1'b1;
    a_chan_i = req;
    @(posedge clk_i);
    while (!a_gnt_o) begin
      @(posedge clk_i);
    end
    exp_q.push_back(apply_model(req));
  endtask

  task automatic drain();
    #2;
    a_req_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
  endtask

  function automatic obi_a_chan_t make_req(input addr_t addr, input logic we,
                                           input be_t be, input atop_e atop);
    obi_a_chan_t req;
    req.addr  = addr;
    req.we    = we;
    req.be    = be;
    req.wdata = {next_rand(), next_rand()};
    req.aid   = id_t'(next_rand());
    req.atop  = atop;
    return req;
  endfunction

  task automatic read_check(input addr_t addr);
    send(make_req(addr, 1'b0, '1, ATOP_NONE));
    drain();
    check_data(cur_test, get_word(word_index(addr)), last_rdata);
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i && r_valid_o && r_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("A response arrived with no request outstanding");
        $display("TEST FAIL");
        $fatal(1);
      end else begin
        check_rsp(cur_test, exp_q[0], r_chan_o);
        last_rdata = r_chan_o.rdata;
        void'(exp_q.pop_front());
      end
    end
  end

  always @(posedge clk_i) begin
    rdy_q = xorshift(rdy_q);
    #2;
    r_ready_i = bp_en ? rdy_q[7] : 1'b1;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("The run timed out after %0d cycles", cycle_cnt);
      $display("TEST FAIL");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_write_read();
    addr_t addrs [16];
    cur_test = "test_write_read";
    for (int w = 0; w < NumWords; w++) begin
      send(make_req(addr_t'(w * 8), 1'b1, '1, ATOP_NONE));
    end
    for (int i = 0; i < 16; i++) begin
      addrs[i] = next_rand() & 32'h7f8;
      send(make_req(addrs[i], 1'b1, be_t'(next_rand()), ATOP_NONE));
    end
    drain();
    for (int i = 0; i < 16; i++) begin
      read_check(addrs[i]);
    end
  endtask

  task automatic test_pipelined_backpressure();
    cur_test = "test_pipelined_backpressure";
    bp_en    = 1'b1;
    for (int i = 0; i < 32; i++) begin
      send(make_req(next_rand() & 32'h7f8, 1'(next_rand()), be_t'(next_rand()), ATOP_NONE));
    end
    drain();
    bp_en = 1'b0;
  endtask

  task automatic test_atomics();
    atop_e ops [6] = '{ATOP_SWAP, ATOP_ADD, ATOP_AND, ATOP_OR, ATOP_MAX, ATOP_MINU};
    addr_t addr;
    obi_a_chan_t req;
    cur_test = "test_atomics";
    foreach (ops[i]) begin
      for (int h = 0; h < 2; h++) begin
        addr = (next_rand() & 32'h7f8) | addr_t'(h * 4);
        req  = make_req(addr, 1'b1, '1, ops[i]);
        // Operand sign opposite to the stored half, so signed and unsigned compares differ
        req.wdata[h*32+31] = ~shadow[word_index(addr)*8+h*4+3][7];
        send(req);
        drain();
        read_check(addr);
      end
    end
  endtask

  task automatic test_lr_sc();
    addr_t a;
    addr_t b;
    cur_test = "test_lr_sc";
    a = (next_rand() & 32'h7f8) | 32'h4;
    b = a ^ 32'h100;
    send(make_req(a, 1'b0, '1, ATOP_LR));
    send(make_req(a, 1'b1, '1, ATOP_SC));
    send(make_req(a, 1'b1, '1, ATOP_SC));
    drain();
    read_check(a);
    send(make_req(a, 1'b0, '1, ATOP_LR));
    send(make_req(a, 1'b1, '1, ATOP_NONE));
    send(make_req(a, 1'b1, '1, ATOP_SC));
    drain();
    read_check(a);
    send(make_req(a, 1'b0, '1, ATOP_LR));
    send(make_req(b, 1'b1, '1, ATOP_SC));
    drain();
    read_check(b);
  endtask

  task automatic test_address_wrap();
    addr_t low;
    addr_t high;
    cur_test = "test_address_wrap";
    low  = next_rand() & 32'h7f8;
    high = low | (next_rand() & ~32'h7ff) | 32'h800;
    send(make_req(high, 1'b1, '1, ATOP_NONE));
    drain();
    read_check(low);
    read_check(high);
  endtask

  initial begin
    rst_n_i   = 1'b0;
    a_req_i   = 1'b0;
    a_chan_i  = '0;
    r_ready_i = 1'b1;
    res_valid = 1'b0;
    res_word  = 0;
    rdy_q     = xorshift(32'hcf09);
    repeat (10) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    test_write_read();
    test_pipelined_backpressure();
    test_atomics();
    test_lr_sc();
    test_address_wrap();
    repeat (4) @(posedge clk_i);
    if (exp_q.size() == 0) begin
      $display("TEST PASS");
    end else begin
      $display("Responses are still missing at the end of the run");
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* mem_tile.f */
+incdir+source
source/memtile_pkg.sv
source/obi_chan_cut.sv
source/obi_atop_resolver.sv
source/obi_sram_shim.sv
source/sram_macro.sv
source/sram_bank_array.sv
source/mem_tile.sv
bench/mem_tile_asserts.sv
bench/mem_tile_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then judge the log
rm -f sim.log
verilator --binary --timing --assert --top-module mem_tile_tb -f mem_tile.f -o mem_tile_sim \
  && ./obj_dir/mem_tile_sim > sim.log 2>&1
test -f sim.log || { echo "Build failed"; exit 1; }
grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"

/* source/mem_tile.sv */
//////////////////////////////////////////////////
// Memory tile top, one OBI manager port
// Responses return in order, at least three cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_tile (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     a_req_i,
  output logic                     a_gnt_o,
  input  memtile_pkg::obi_a_chan_t a_chan_i,
  output logic                     r_valid_o,
  input  logic                     r_ready_i,
  output memtile_pkg::obi_r_chan_t r_chan_o
);

  import memtile_pkg::*;

  logic        rslv_valid, rslv_ready;
  obi_a_chan_t rslv_chan;
  logic        cut_valid, cut_ready;
  obi_a_chan_t cut_chan;
  logic        shim_rvalid, shim_rready;
  obi_r_chan_t shim_rchan;
  logic        rsp_valid, rsp_ready;
  obi_r_chan_t rsp_chan;
  logic        mem_req;
  sram_req_t   mem;
  data_t       mem_rdata;

  //////////////////////////////////////////////////
  // Atomics and request cut
  //////////////////////////////////////////////////

  obi_atop_resolver u_resolver (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .sbr_req_i   (a_req_i),
    .sbr_gnt_o   (a_gnt_o),
    .sbr_chan_i  (a_chan_i),
    .sbr_rvalid_o(r_valid_o),
    .sbr_rready_i(r_ready_i),
    .sbr_rchan_o (r_chan_o),
    .mgr_valid_o (rslv_valid),
    .mgr_ready_i (rslv_ready),
    .mgr_chan_o  (rslv_chan),
    .mgr_rvalid_i(rsp_valid),
    .mgr_rready_o(rsp_ready),
    .mgr_rchan_i (rsp_chan)
  );

  obi_chan_cut #(
    .payload_t(obi_a_chan_t)
  ) u_req_cut (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(rslv_valid),
    .ready_o(rslv_ready),
    .data_i (rslv_chan),
    .valid_o(cut_valid),
    .ready_i(cut_ready),
    .data_o (cut_chan)
  );

  //////////////////////////////////////////////////
  // SRAM path and response cut
  //////////////////////////////////////////////////

  obi_sram_shim u_shim (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(cut_valid),
    .req_ready_o(cut_ready),
    .req_chan_i (cut_chan),
    .rsp_valid_o(shim_rvalid),
    .rsp_ready_i(shim_rready),
    .rsp_chan_o (shim_rchan),
    .mem_req_o  (mem_req),
    .mem_o      (mem),
    .mem_rdata_i(mem_rdata)
  );

  sram_bank_array u_banks (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .mem_req_i  (mem_req),
    .mem_i      (mem),
    .mem_rdata_o(mem_rdata)
  );

  obi_chan_cut #(
    .payload_t(obi_r_chan_t)
  ) u_rsp_cut (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(shim_rvalid),
    .ready_o(shim_rready),
    .data_i (shim_rchan),
    .valid_o(rsp_valid),
    .ready_i(rsp_ready),
    .data_o (rsp_chan)
  );

endmodule

/* source/memtile_config.svh */
//////////////////////////////////////////////////
// Tile geometry and channel widths
// Data width must be 64 for the 32-bit atomic halves
// Tile size is rows x words per macro x word bytes
//////////////////////////////////////////////////

`ifndef MEMTILE_CONFIG_SVH
`define MEMTILE_CONFIG_SVH

// Word and address widths
`define MEMTILE_DATA_WIDTH 64
`define MEMTILE_ADDR_WIDTH 32
`define MEMTILE_ID_WIDTH 4

// Bank organisation, 2 KiB in total
`define MEMTILE_BANKS_PER_WORD 2
`define MEMTILE_BANK_ROWS 4
`define MEMTILE_WORDS_PER_MACRO 64

`endif

/* source/memtile_pkg.sv */
//////////////////////////////////////////////////
// Channel and strobe types of the memory tile
// Widths come from memtile_config.svh
//////////////////////////////////////////////////

`include "memtile_config.svh"

package memtile_pkg;

  typedef logic [`MEMTILE_DATA_WIDTH-1:0]   data_t;
  typedef logic [`MEMTILE_DATA_WIDTH/8-1:0] be_t;
  typedef logic [`MEMTILE_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`MEMTILE_ID_WIDTH-1:0]     id_t;

  // Index of a full data word inside the tile
  typedef logic [$clog2(`MEMTILE_BANK_ROWS * `MEMTILE_WORDS_PER_MACRO)-1:0] word_addr_t;

  typedef enum logic [3:0] {
    ATOP_NONE,
    ATOP_LR,
    ATOP_SC,
    ATOP_SWAP,
    ATOP_ADD,
    ATOP_AND,
    ATOP_OR,
    ATOP_MAX,
    ATOP_MINU
  } atop_e;

  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
    id_t   aid;
    atop_e atop;
  } obi_a_chan_t;

  typedef struct packed {
    data_t rdata;
    id_t   rid;
    logic  exokay;
  } obi_r_chan_t;

  typedef struct packed {
    logic       we;
    word_addr_t addr;
    data_t      wdata;
    be_t        be;
  } sram_req_t;

endpackage

/* source/obi_atop_resolver.sv */
//////////////////////////////////////////////////
// Resolves RISC-V atomics and LR/SC as read-modify-write
// Atomics act on the 32-bit half picked by addr[2]
// One reservation, tracked per 64-bit word
// At most four plain accesses in flight
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "memtile_config.svh"

module obi_atop_resolver (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     sbr_req_i,
  output logic                     sbr_gnt_o,
  input  memtile_pkg::obi_a_chan_t sbr_chan_i,
  output logic                     sbr_rvalid_o,
  input  logic                     sbr_rready_i,
  output memtile_pkg::obi_r_chan_t sbr_rchan_o,
  output logic                     mgr_valid_o,
  input  logic                     mgr_ready_i,
  output memtile_pkg::obi_a_chan_t mgr_chan_o,
  input  logic                     mgr_rvalid_i,
  output logic                     mgr_rready_o,
  input  memtile_pkg::obi_r_chan_t mgr_rchan_i
);

  import memtile_pkg::*;

  localparam int unsigned MaxOutstanding = 4;
  localparam int unsigned ByteOffset     = $clog2(`MEMTILE_DATA_WIDTH / 8);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD,
    ST_RD_WAIT,
    ST_WR,
    ST_WR_WAIT,
    ST_RSP
  } state_e;

  state_e      state_q, state_d;
  logic [2:0]  cnt_q;
  obi_a_chan_t amo_q;
  logic [31:0] result_q;
  logic [31:0] new_q;
  logic        exokay_q;
  logic        res_valid_q;
  word_addr_t  res_addr_q;

  logic        is_plain;
  logic        plain_fwd;
  logic        rsp_fwd;
  logic        amo_gnt;
  logic        rd_done;
  logic        res_hit;
  logic [31:0] old_half;
  logic [31:0] op_half;

  function automatic word_addr_t word_of(addr_t addr);
    return word_addr_t'(addr >> ByteOffset);
  endfunction

  function automatic logic [31:0] amo_alu(atop_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      ATOP_SWAP, ATOP_SC: return b;
      ATOP_ADD:           return a + b;
      ATOP_AND:           return a & b;
      ATOP_OR:            return a | b;
      ATOP_MAX:           return ($signed(a) > $signed(b)) ? a : b;
      ATOP_MINU:          return (a < b) ? a : b;
      default:            return a;
    endcase
  endfunction

  assign is_plain  = (sbr_chan_i.atop == ATOP_NONE);
  assign plain_fwd = (state_q == ST_IDLE) && mgr_valid_o && mgr_ready_i;
  assign rsp_fwd   = (state_q == ST_IDLE) && mgr_rvalid_i && sbr_rready_i;
  assign amo_gnt   = (state_q == ST_IDLE) && sbr_gnt_o && !is_plain;
  assign rd_done   = (state_q == ST_RD_WAIT) && mgr_rvalid_i;
  assign res_hit   = res_valid_q && (res_addr_q == word_of(amo_q.addr));

  // Operand halves, selected by address bit 2
  assign old_half = amo_q.addr[2] ? mgr_rchan_i.rdata[32+:32] : mgr_rchan_i.rdata[0+:32];
  assign op_half  = amo_q.addr[2] ? amo_q.wdata[32+:32] : amo_q.wdata[0+:32];

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  always_comb begin
    mgr_valid_o = 1'b0;
    mgr_chan_o  = sbr_chan_i;
    sbr_gnt_o   = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (is_plain) begin
          mgr_valid_o = sbr_req_i && (cnt_q < 3'(MaxOutstanding));
          sbr_gnt_o   = mgr_valid_o && mgr_ready_i;
        end else begin
          // Atomics wait for the pipeline to drain
          sbr_gnt_o = sbr_req_i && (cnt_q == 3'd0);
        end
      end
      ST_RD: begin
        mgr_valid_o     = 1'b1;
        mgr_chan_o      = amo_q;
        mgr_chan_o.we   = 1'b0;
        mgr_chan_o.atop = ATOP_NONE;
      end
      ST_WR: begin
        mgr_valid_o      = 1'b1;
        mgr_chan_o       = amo_q;
        mgr_chan_o.we    = 1'b1;
        mgr_chan_o.be    = {{4{amo_q.addr[2]}}, {4{~amo_q.addr[2]}}};
        mgr_chan_o.wdata = {2{new_q}};
        mgr_chan_o.atop  = ATOP_NONE;
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////

  // Internal responses of a sequence are absorbed here
  assign sbr_rvalid_o = (state_q == ST_IDLE) ? mgr_rvalid_i : (state_q == ST_RSP);
  assign mgr_rready_o = (state_q == ST_IDLE) ? sbr_rready_i :
                        ((state_q == ST_RD_WAIT) || (state_q == ST_WR_WAIT));

  always_comb begin
    sbr_rchan_o = mgr_rchan_i;
    if (state_q != ST_IDLE) begin
      sbr_rchan_o.rdata  = amo_q.addr[2] ? {result_q, 32'h0} : {32'h0, result_q};
      sbr_rchan_o.rid    = amo_q.aid;
      sbr_rchan_o.exokay = exokay_q;
    end
  end

  //////////////////////////////////////////////////
  // Sequence FSM and reservation
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (amo_gnt) begin
          state_d = ST_RD;
        end
      end
      ST_RD: begin
        if (mgr_ready_i) begin
          state_d = ST_RD_WAIT;
        end
      end
      ST_RD_WAIT: begin
        // LR and a failed SC skip the write
        if (mgr_rvalid_i) begin
          if (amo_q.atop == ATOP_LR || (amo_q.atop == ATOP_SC && !res_hit)) begin
            state_d = ST_RSP;
          end else begin
            state_d = ST_WR;
          end
        end
      end
      ST_WR: begin
        if (mgr_ready_i) begin
          state_d = ST_WR_WAIT;
        end
      end
      ST_WR_WAIT: begin
        if (mgr_rvalid_i) begin
          state_d = ST_RSP;
        end
      end
      ST_RSP: begin
        if (sbr_rready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      cnt_q       <= 3'd0;
      res_valid_q <= 1'b0;
      res_addr_q  <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_q + 3'(plain_fwd) - 3'(rsp_fwd);
      if (plain_fwd && sbr_chan_i.we && (word_of(sbr_chan_i.addr) == res_addr_q)) begin
        res_valid_q <= 1'b0;
      end
      if (rd_done) begin
        case (amo_q.atop)
          ATOP_LR: begin
            res_valid_q <= 1'b1;
            res_addr_q  <= word_of(amo_q.addr);
          end
          ATOP_SC: res_valid_q <= 1'b0;
          default: begin
            if (res_hit) begin
              res_valid_q <= 1'b0;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (amo_gnt) begin
      amo_q <= sbr_chan_i;
    end
    if (rd_done) begin
      new_q    <= amo_alu(amo_q.atop, old_half, op_half);
      exokay_q <= (amo_q.atop == ATOP_LR) || (amo_q.atop == ATOP_SC && res_hit);
      if (amo_q.atop == ATOP_SC) begin
        result_q <= res_hit ? 32'd0 : 32'd1;
      end else begin
        result_q <= old_half;
      end
    end
  end

endmodule

/* source/obi_chan_cut.sv */
//////////////////////////////////////////////////
// Two-entry register slice, valid and ready cut
// Output is valid one cycle after acceptance
//////////////////////////////////////////////////

`timescale 1ns/1ps

module obi_chan_cut #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  payload_t   mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] cnt_q;
  logic       push;
  logic       pop;

  // Ready depends on the fill level only
  assign ready_o = (cnt_q != 2'd2);
  assign valid_o = (cnt_q != 2'd0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i && ready_o;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      cnt_q    <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      cnt_q <= cnt_q + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

/* source/obi_sram_shim.sv */
//////////////////////////////////////////////////
// OBI to SRAM strobes, response one cycle after grant
// Upper address bits are dropped, so addresses wrap
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "memtile_config.svh"

module obi_sram_shim (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  memtile_pkg::obi_a_chan_t req_chan_i,
  output logic                     rsp_valid_o,
  input  logic                     rsp_ready_i,
  output memtile_pkg::obi_r_chan_t rsp_chan_o,
  output logic                     mem_req_o,
  output memtile_pkg::sram_req_t   mem_o,
  input  memtile_pkg::data_t       mem_rdata_i
);

  import memtile_pkg::*;

  localparam int unsigned ByteOffset = $clog2(`MEMTILE_DATA_WIDTH / 8);

  logic        pend_q;
  logic        hold_valid_q;
  logic        we_q;
  id_t         id_q;
  obi_r_chan_t hold_q;
  obi_r_chan_t rsp;

  assign req_ready_o = !hold_valid_q && (!pend_q || rsp_ready_i);
  assign mem_req_o   = req_valid_i && req_ready_o;

  assign mem_o.we    = req_chan_i.we;
  assign mem_o.addr  = word_addr_t'(req_chan_i.addr >> ByteOffset);
  assign mem_o.wdata = req_chan_i.wdata;
  assign mem_o.be    = req_chan_i.be;

  // SRAM data lives for one cycle only
  assign rsp.rdata  = we_q ? '0 : mem_rdata_i;
  assign rsp.rid    = id_q;
  assign rsp.exokay = 1'b0;

  assign rsp_valid_o = pend_q || hold_valid_q;
  assign rsp_chan_o  = hold_valid_q ? hold_q : rsp;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q       <= 1'b0;
      hold_valid_q <= 1'b0;
    end else begin
      pend_q <= mem_req_o;
      if (hold_valid_q) begin
        hold_valid_q <= !rsp_ready_i;
      end else if (pend_q && !rsp_ready_i) begin
        hold_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_req_o) begin
      we_q <= req_chan_i.we;
      id_q <= req_chan_i.aid;
    end
    if (pend_q && !hold_valid_q && !rsp_ready_i) begin
      hold_q <= rsp;
    end
  end

endmodule

/* source/sram_bank_array.sv */
//////////////////////////////////////////////////
// Word split over banks, each bank over row macros
// Read data is valid one cycle after the strobe
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "memtile_config.svh"

module sram_bank_array (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   mem_req_i,
  input  memtile_pkg::sram_req_t mem_i,
  output memtile_pkg::data_t     mem_rdata_o
);

  localparam int unsigned NumBanks       = `MEMTILE_BANKS_PER_WORD;
  localparam int unsigned NumRows        = `MEMTILE_BANK_ROWS;
  localparam int unsigned BankWidth      = `MEMTILE_DATA_WIDTH / NumBanks;
  localparam int unsigned MacroAddrWidth = $clog2(`MEMTILE_WORDS_PER_MACRO);
  localparam int unsigned RowSelWidth    = $clog2(NumRows);

  logic [MacroAddrWidth-1:0]                          macro_addr;
  logic [RowSelWidth-1:0]                             row_sel;
  logic [RowSelWidth-1:0]                             row_sel_q;
  logic [NumRows-1:0][NumBanks-1:0][BankWidth-1:0]    rdata_split;

  // Low word bits address the macro, high bits pick the row
  assign macro_addr = mem_i.addr[MacroAddrWidth-1:0];
  assign row_sel    = mem_i.addr[MacroAddrWidth+:RowSelWidth];

  // Remember the row for next cycle's read mux
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      row_sel_q <= '0;
    end else if (mem_req_i && !mem_i.we) begin
      row_sel_q <= row_sel;
    end
  end

  for (genvar i = 0; i < NumBanks; i++) begin : gen_banks
    assign mem_rdata_o[i*BankWidth+:BankWidth] = rdata_split[row_sel_q][i];

    for (genvar j = 0; j < NumRows; j++) begin : gen_rows
      sram_macro #(
        .NumWords (`MEMTILE_WORDS_PER_MACRO),
        .DataWidth(BankWidth)
      ) u_macro (
        .clk_i  (clk_i),
        .req_i  (mem_req_i && (row_sel == RowSelWidth'(j))),
        .we_i   (mem_i.we),
        .addr_i (macro_addr),
        .wdata_i(mem_i.wdata[i*BankWidth+:BankWidth]),
        .be_i   (mem_i.be[i*BankWidth/8+:BankWidth/8]),
        .rdata_o(rdata_split[j][i])
      );
    end
  end

endmodule

/* source/sram_macro.sv */
//////////////////////////////////////////////////
// Behavioral single-port SRAM, byte writes
// Read output registered, holds until next read
//////////////////////////////////////////////////

`timescale 1ns/1ps

module sram_macro #(
  parameter int unsigned NumWords  = 64,
  parameter int unsigned DataWidth = 32
) (
  input  logic                        clk_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(NumWords)-1:0] addr_i,
  input  logic [DataWidth-1:0]        wdata_i,
  input  logic [DataWidth/8-1:0]      be_i,
  output logic [DataWidth-1:0]        rdata_o
);

  logic [DataWidth-1:0] mem_q [NumWords];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < DataWidth / 8; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8+:8] <= wdata_i[b*8+:8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule
